/* dummy_insert.f */
+incdir+source
source/rv_instr_pkg.sv
source/dummy_cfg_pkg.sv
source/dummy_lfsr_bank.sv
source/dummy_interval_counter.sv
source/dummy_instr_gen.sv
source/dummy_ctrl_fsm.sv
source/dummy_insert_top.sv
dv/dummy_insert_props.sv
dv/dummy_insert_tb.sv

/* Makefile */
TOP := dummy_insert_tb
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f dummy_insert.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^Simulation passed$$" $(LOG)

lint:
	verilator --lint-only --timing -f dummy_insert.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

/* dv/dummy_insert_tb.sv */
`timescale 1ns/10ps

`include "dummy_settings.svh"

module dummy_insert_tb;

  localparam int PHASES     = 20;
  localparam int PHASE_LEN  = 150;
  localparam int MAX_CYCLES = PHASES * PHASE_LEN + 1000;

  logic                      clk_i = 1'b0;
  logic                      rst_ni;
  logic                      fetch_valid;
  logic [31:0]               fetch_instr;
  logic                      fetch_ready;
  logic                      id_ready;
  logic                      dummy_en;
  logic [3:0]                dummy_freq;
  logic                      seed_we;
  dummy_cfg_pkg::lfsr_sel_e  seed_sel;
  logic [31:0]               seed_wdata;
  logic                      issue_valid;
  logic [31:0]               issue_instr;
  logic                      issue_dummy;
  logic [31:0]               issue_op_a;
  logic [31:0]               issue_op_b;

  // Reference model state
  dummy_cfg_pkg::ctrl_state_e m_state;
  logic [5:0]                 m_cnt;
  logic [5:0]                 m_thr;
  logic [31:0]                m_lfsr [3];
  logic [31:0]                rng = 32'h9511_cbf9;
  logic                       taken;
  logic                       clean;
  int                         normals_since;
  int                         dummy_count;
  int                         normal_count;
  int                         cycle_count;
  int                         error_count;

  always #2 clk_i = ~clk_i;

  dummy_insert_top dummy_insert_top_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .fetch_valid (fetch_valid),
    .fetch_instr (fetch_instr),
    .fetch_ready (fetch_ready),
    .id_ready    (id_ready),
    .dummy_en    (dummy_en),
    .dummy_freq  (dummy_freq),
    .seed_we     (seed_we),
    .seed_sel    (seed_sel),
    .seed_wdata  (seed_wdata),
    .issue_valid (issue_valid),
    .issue_instr (issue_instr),
    .issue_dummy (issue_dummy),
    .issue_op_a  (issue_op_a),
    .issue_op_b  (issue_op_b)
  );

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic logic [5:0] class_mask(input logic [3:0] f);
    if (f >= 4'd8) return 6'd63;
    if (f >= 4'd4) return 6'd31;
    if (f >= 4'd2) return 6'd15;
    if (f == 4'd1) return 6'd7;
    return 6'd3;
  endfunction

  function automatic logic [31:0] default_seed(input int i);
    if (i == 0) return `DUMMY_SEED0;
    if (i == 1) return `DUMMY_SEED1;
    return `DUMMY_SEED2;
  endfunction

  function automatic logic [31:0] galois_step(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ `DUMMY_LFSR_TAPS;
    end
    return n;
  endfunction

  // Encodings taken straight from the base ISA and M extension tables
  function automatic logic [31:0] expected_dummy(input logic [31:0] l0, input logic [31:0] l1,
                                                 input logic [31:0] l2);
    logic [4:0] rs1;
    logic [4:0] rs2;
    rs1 = l1[4:0];
    rs2 = l2[4:0];
    case (l0[31:30])
      2'd0:    return {7'b0000000, rs2, rs1, 3'b000, 5'd0, 7'b0110011};
      2'd1:    return {7'b0000000, rs2, rs1, 3'b111, 5'd0, 7'b0110011};
      2'd2:    return {7'b0000001, rs2, rs1, 3'b000, 5'd0, 7'b0110011};
      default: return {7'b0000000, rs2, rs1, 3'b110, 5'd0, 7'b1100011};
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      error_count++;
      $display("** Error: %s is %h, expected %h", name, got, exp);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic reset_model();
    m_state = dummy_cfg_pkg::ST_OFF;
    m_cnt   = '0;
    for (int i = 0; i < 3; i++) begin
      m_lfsr[i] = default_seed(i);
    end
    // Reset reloads the threshold from the default lfsr0
    m_thr = m_lfsr[0][5:0] & class_mask(dummy_freq);
    clean = 1'b0;
    normals_since = 0;
  endtask

  // Compares the outputs of this cycle, then moves the model past the next edge
  task automatic check_and_advance();
    logic        due;
    logic        hold;
    logic        exp_valid;
    logic        exp_dummy;
    logic        exp_fready;
    logic [31:0] exp_a;
    logic [31:0] exp_b;
    logic        nacc;
    logic        dacc;
    logic        obs_n;
    logic        obs_d;
    logic [31:0] nxt;
    due  = (m_cnt == m_thr);
    hold = (m_state == dummy_cfg_pkg::ST_RUN) && dummy_en && due;
    exp_a = '0;
    exp_b = '0;
    if (m_state == dummy_cfg_pkg::ST_DUMMY) begin
      exp_valid  = 1'b1;
      exp_dummy  = 1'b1;
      exp_fready = 1'b0;
      exp_a = (m_lfsr[1][4:0] == 5'd0) ? 32'd0 : m_lfsr[1];
      exp_b = (m_lfsr[2][4:0] == 5'd0) ? 32'd0 : m_lfsr[2];
    end else begin
      exp_valid  = fetch_valid && !hold;
      exp_dummy  = 1'b0;
      exp_fready = id_ready && !hold;
    end
    check_value("fetch_ready", 32'(fetch_ready), 32'(exp_fready));
    check_value("issue_valid", 32'(issue_valid), 32'(exp_valid));
    check_value("issue_dummy", 32'(issue_dummy), 32'(exp_dummy));
    check_value("issue_op_a", issue_op_a, exp_a);
    check_value("issue_op_b", issue_op_b, exp_b);
    if (exp_dummy) begin
      check_value("issue_instr", issue_instr, expected_dummy(m_lfsr[0], m_lfsr[1], m_lfsr[2]));
    end else if (exp_valid) begin
      check_value("issue_instr", issue_instr, fetch_instr);
    end
    nacc  = exp_valid && id_ready && !exp_dummy;
    dacc  = exp_valid && id_ready && exp_dummy;
    obs_n = issue_valid && id_ready && !issue_dummy;
    obs_d = issue_valid && id_ready && issue_dummy;
    taken = fetch_valid && fetch_ready;
    if (!dummy_en) begin
      clean = 1'b0;
    end
    if (obs_n) begin
      normal_count++;
      normals_since++;
    end
    if (obs_d) begin
      dummy_count++;
      // The spacing rule is only fixed when insertion stayed on over the whole gap
      if (clean) begin
        check_value("normal_gap", 32'(normals_since), 32'(m_thr));
      end
      clean = dummy_en;
      normals_since = 0;
    end
    // Counter uses lfsr0 from before the step
    if (!dummy_en || dacc) begin
      m_cnt = '0;
      m_thr = m_lfsr[0][5:0] & class_mask(dummy_freq);
    end else if (nacc && !due) begin
      m_cnt = m_cnt + 6'd1;
    end
    for (int i = 0; i < 3; i++) begin
      if (seed_we && int'(seed_sel) == i) begin
        m_lfsr[i] = (seed_wdata == '0) ? default_seed(i) : seed_wdata;
      end else if (dacc) begin
        nxt = galois_step(m_lfsr[i]);
        m_lfsr[i] = (nxt == '0) ? default_seed(i) : nxt;
      end
    end
    case (m_state)
      dummy_cfg_pkg::ST_OFF: begin
        if (dummy_en) m_state = dummy_cfg_pkg::ST_RUN;
      end
      dummy_cfg_pkg::ST_RUN: begin
        if (!dummy_en) begin
          m_state = dummy_cfg_pkg::ST_OFF;
        end else if (due && !nacc) begin
          m_state = dummy_cfg_pkg::ST_DUMMY;
        end
      end
      default: begin
        if (dacc) m_state = dummy_en ? dummy_cfg_pkg::ST_RUN : dummy_cfg_pkg::ST_OFF;
      end
    endcase
  endtask

  task automatic drive_inputs(input int cyc);
    logic [31:0] r;
    logic [31:0] w;
    if (cyc % PHASE_LEN == 0) begin
      r = next_rand();
      dummy_en   <= (r % 5) != 0;
      dummy_freq <= r[11:8];
    end
    // The fetch side keeps its word until decode takes it
    if (!fetch_valid || taken) begin
      r = next_rand();
      fetch_valid <= (r % 4) != 0;
      w = next_rand();
      fetch_instr <= w;
    end
    r = next_rand();
    id_ready <= (r % 4) != 0;
    r = next_rand();
    if (m_state != dummy_cfg_pkg::ST_DUMMY && (r % 40) == 0) begin
      w = next_rand();
      seed_we    <= 1'b1;
      seed_sel   <= dummy_cfg_pkg::lfsr_sel_e'(r[9:8] % 3);
      seed_wdata <= (w[1:0] == 2'd0) ? 32'd0 : w;
    end else begin
      seed_we <= 1'b0;
    end
  endtask

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Run did not finish within %0d cycles", MAX_CYCLES);
      $display("Simulation failed");
      $fatal(1);
    end
  end

  initial begin
    rst_ni      = 1'b0;
    fetch_valid = 1'b0;
    fetch_instr = '0;
    id_ready    = 1'b0;
    dummy_en    = 1'b0;
    dummy_freq  = '0;
    seed_we     = 1'b0;
    seed_sel    = dummy_cfg_pkg::LFSR0;
    seed_wdata  = '0;
    taken       = 1'b0;
    reset_model();
    // Reset is sampled low on two rising edges, released after the second
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    // First cycle out of reset keeps the fetch side idle
    @(negedge clk_i);
    check_and_advance();
    for (int cyc = 0; cyc < PHASES * PHASE_LEN; cyc++) begin
      @(posedge clk_i);
      drive_inputs(cyc);
      @(negedge clk_i);
      check_and_advance();
    end
    if (dummy_count == 0 || normal_count == 0) begin
      error_count++;
      $display("No dummy or no normal instruction was ever transferred");
    end
    if (error_count == 0) begin
      $display("Simulation passed");
      $finish;
    end else begin
      $display("Simulation failed");
      $fatal(1);
    end
  end

endmodule

/* dv/dummy_insert_props.sv */
`timescale 1ns/10ps

`include "dummy_settings.svh"

module dummy_insert_props (
  input logic                       clk_i,
  input logic                       rst_ni,
  input dummy_cfg_pkg::ctrl_state_e state,
  input logic                       fetch_ready,
  input logic                       issue_valid,
  input logic                       id_ready,
  input logic                       issue_dummy,
  input logic [31:0]                issue_instr,
  input logic [`DUMMY_LFSR_W-1:0]   issue_op_a,
  input logic [`DUMMY_LFSR_W-1:0]   issue_op_b
);

  // The dummy owns the issue port, nothing may leave the fetch side
  a_no_fetch_in_dummy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state == dummy_cfg_pkg::ST_DUMMY |-> !fetch_ready)
    else $error("fetch_ready high in ST_DUMMY");

  a_dummy_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_valid && issue_dummy && !id_ready |=> issue_valid && issue_dummy
      && $stable(issue_instr) && $stable(issue_op_a) && $stable(issue_op_b))
    else $error("stalled dummy changed on the issue port");

  a_idle_after_reset: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> !issue_valid && !issue_dummy)
    else $error("issue port active right after reset");

  // Only the branch form has no rd field
  a_dummy_rd_x0: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_valid && id_ready && issue_dummy
      && issue_instr[6:0] != rv_instr_pkg::OPCODE_BRANCH
      |-> issue_instr[11:7] == rv_instr_pkg::REG_X0)
    else $error("dummy writes a register other than x0");

endmodule

bind dummy_insert_top dummy_insert_props dummy_insert_props_inst (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .state       (dummy_ctrl_fsm_inst.state_q),
  .fetch_ready (fetch_ready),
  .issue_valid (issue_valid),
  .id_ready    (id_ready),
  .issue_dummy (issue_dummy),
  .issue_instr (issue_instr),
  .issue_op_a  (issue_op_a),
  .issue_op_b  (issue_op_b)
);

/* source/dummy_insert_top.sv */
`timescale 1ns/10ps

`include "dummy_settings.svh"

module dummy_insert_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     fetch_valid,
  input  logic [31:0]              fetch_instr,
  output logic                     fetch_ready,
  input  logic                     id_ready,
  input  logic                     dummy_en,
  input  logic [3:0]               dummy_freq,
  input  logic                     seed_we,
  input  dummy_cfg_pkg::lfsr_sel_e seed_sel,
  input  logic [`DUMMY_LFSR_W-1:0] seed_wdata,
  output logic                     issue_valid,
  output logic [31:0]              issue_instr,
  output logic                     issue_dummy,
  output logic [`DUMMY_LFSR_W-1:0] issue_op_a,
  output logic [`DUMMY_LFSR_W-1:0] issue_op_b
);

  logic [`DUMMY_LFSR_W-1:0] lfsr0;
  logic [`DUMMY_LFSR_W-1:0] lfsr1;
  logic [`DUMMY_LFSR_W-1:0] lfsr2;
  logic                     dummy_due;
  logic                     normal_accept;
  logic                     dummy_accept;
  rv_instr_pkg::instr_u     dummy_instr;
  logic [`DUMMY_LFSR_W-1:0] dummy_op_a;
  logic [`DUMMY_LFSR_W-1:0] dummy_op_b;

  // The LFSRs advance once per dummy that decode accepts
  dummy_lfsr_bank dummy_lfsr_bank_inst (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .step       (dummy_accept),
    .seed_we    (seed_we),
    .seed_sel   (seed_sel),
    .seed_wdata (seed_wdata),
    .lfsr0      (lfsr0),
    .lfsr1      (lfsr1),
    .lfsr2      (lfsr2)
  );

  dummy_interval_counter dummy_interval_counter_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .dummy_en      (dummy_en),
    .dummy_freq    (dummy_freq),
    .lfsr0         (lfsr0),
    .normal_accept (normal_accept),
    .dummy_accept  (dummy_accept),
    .dummy_due     (dummy_due)
  );

  dummy_instr_gen dummy_instr_gen_inst (
    .lfsr0       (lfsr0),
    .lfsr1       (lfsr1),
    .lfsr2       (lfsr2),
    .dummy_instr (dummy_instr),
    .dummy_op_a  (dummy_op_a),
    .dummy_op_b  (dummy_op_b)
  );

  dummy_ctrl_fsm dummy_ctrl_fsm_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .dummy_en      (dummy_en),
    .dummy_due     (dummy_due),
    .fetch_valid   (fetch_valid),
    .fetch_instr   (fetch_instr),
    .id_ready      (id_ready),
    .dummy_instr   (dummy_instr),
    .dummy_op_a    (dummy_op_a),
    .dummy_op_b    (dummy_op_b),
    .fetch_ready   (fetch_ready),
    .issue_valid   (issue_valid),
    .issue_instr   (issue_instr),
    .issue_dummy   (issue_dummy),
    .issue_op_a    (issue_op_a),
    .issue_op_b    (issue_op_b),
    .normal_accept (normal_accept),
    .dummy_accept  (dummy_accept)
  );

endmodule

/* source/dummy_ctrl_fsm.sv */
`timescale 1ns/10ps

`include "dummy_settings.svh"

module dummy_ctrl_fsm (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     dummy_en,
  input  logic                     dummy_due,
  input  logic                     fetch_valid,
  input  logic [31:0]              fetch_instr,
  input  logic                     id_ready,
  input  rv_instr_pkg::instr_u     dummy_instr,
  input  logic [`DUMMY_LFSR_W-1:0] dummy_op_a,
  input  logic [`DUMMY_LFSR_W-1:0] dummy_op_b,
  output logic                     fetch_ready,
  output logic                     issue_valid,
  output logic [31:0]              issue_instr,
  output logic                     issue_dummy,
  output logic [`DUMMY_LFSR_W-1:0] issue_op_a,
  output logic [`DUMMY_LFSR_W-1:0] issue_op_b,
  output logic                     normal_accept,
  output logic                     dummy_accept
);

  dummy_cfg_pkg::ctrl_state_e state_q;
  dummy_cfg_pkg::ctrl_state_e state_d;
  logic                       pass_hold;

  // Once a dummy is due in ST_RUN, no further fetched word may slip past it
  assign pass_hold = (state_q == dummy_cfg_pkg::ST_RUN) && dummy_en && dummy_due;

  always_comb begin
    fetch_ready = 1'b0;
    issue_valid = 1'b0;
    issue_instr = fetch_instr;
    issue_dummy = 1'b0;
    issue_op_a  = '0;
    issue_op_b  = '0;
    if (state_q == dummy_cfg_pkg::ST_DUMMY) begin
      issue_valid = 1'b1;
      issue_instr = dummy_instr;
      issue_dummy = 1'b1;
      issue_op_a  = dummy_op_a;
      issue_op_b  = dummy_op_b;
    end else begin
      // Combinational pass-through, decode sees the fetched word in the same cycle
      fetch_ready = id_ready && !pass_hold;
      issue_valid = fetch_valid && !pass_hold;
    end
  end

  assign normal_accept = issue_valid && id_ready && !issue_dummy;
  assign dummy_accept  = issue_valid && id_ready && issue_dummy;

  always_comb begin
    state_d = state_q;
    case (state_q)
      dummy_cfg_pkg::ST_OFF: begin
        if (dummy_en) begin
          state_d = dummy_cfg_pkg::ST_RUN;
        end
      end
      dummy_cfg_pkg::ST_RUN: begin
        if (!dummy_en) begin
          state_d = dummy_cfg_pkg::ST_OFF;
        end else if (dummy_due && !normal_accept) begin
          state_d = dummy_cfg_pkg::ST_DUMMY;
        end
      end
      dummy_cfg_pkg::ST_DUMMY: begin
        // The dummy stays on the port until decode takes it
        if (dummy_accept) begin
          state_d = dummy_en ? dummy_cfg_pkg::ST_RUN : dummy_cfg_pkg::ST_OFF;
        end
      end
      default: state_d = dummy_cfg_pkg::ST_OFF;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= dummy_cfg_pkg::ST_OFF;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

/* source/dummy_instr_gen.sv */
`timescale 1ns/10ps

`include "dummy_settings.svh"

module dummy_instr_gen (
  input  logic [`DUMMY_LFSR_W-1:0] lfsr0,
  input  logic [`DUMMY_LFSR_W-1:0] lfsr1,
  input  logic [`DUMMY_LFSR_W-1:0] lfsr2,
  output rv_instr_pkg::instr_u     dummy_instr,
  output logic [`DUMMY_LFSR_W-1:0] dummy_op_a,
  output logic [`DUMMY_LFSR_W-1:0] dummy_op_b
);

  logic [1:0] kind;
  logic [4:0] rs1;
  logic [4:0] rs2;

  assign kind = lfsr0[`DUMMY_LFSR_W-1 -: 2];
  assign rs1  = lfsr1[4:0];
  assign rs2  = lfsr2[4:0];

  always_comb begin
    dummy_instr          = '0;
    dummy_instr.r.rs1    = rs1;
    dummy_instr.r.rs2    = rs2;
    dummy_instr.r.rd     = rv_instr_pkg::REG_X0;
    dummy_instr.r.opcode = rv_instr_pkg::OPCODE_OP;
    case (kind)
      2'd0: begin
        dummy_instr.r.funct3 = rv_instr_pkg::FUNCT3_ADD;
        dummy_instr.r.funct7 = rv_instr_pkg::FUNCT7_ADD;
      end
      2'd1: begin
        dummy_instr.r.funct3 = rv_instr_pkg::FUNCT3_AND;
        dummy_instr.r.funct7 = rv_instr_pkg::FUNCT7_ADD;
      end
      2'd2: begin
        dummy_instr.r.funct3 = rv_instr_pkg::FUNCT3_ADD;
        dummy_instr.r.funct7 = rv_instr_pkg::FUNCT7_MUL;
      end
      default: begin
        // Zero offset, so the branch lands on the next real instruction either way
        dummy_instr.b          = '0;
        dummy_instr.b.rs1      = rs1;
        dummy_instr.b.rs2      = rs2;
        dummy_instr.b.funct3   = rv_instr_pkg::FUNCT3_BLTU;
        dummy_instr.b.opcode   = rv_instr_pkg::OPCODE_BRANCH;
      end
    endcase
  end

  // x0 always reads zero, so the operand must follow the register file
  assign dummy_op_a = (rs1 == rv_instr_pkg::REG_X0) ? '0 : lfsr1;
  assign dummy_op_b = (rs2 == rv_instr_pkg::REG_X0) ? '0 : lfsr2;

endmodule

/* source/dummy_interval_counter.sv */
`timescale 1ns/10ps

`include "dummy_settings.svh"

module dummy_interval_counter (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     dummy_en,
  input  logic [3:0]               dummy_freq,
  input  logic [`DUMMY_LFSR_W-1:0] lfsr0,
  input  logic                     normal_accept,
  input  logic                     dummy_accept,
  output logic                     dummy_due
);

  localparam int CNT_W = `DUMMY_CNT_W;

  dummy_cfg_pkg::freq_class_e freq_class;
  logic [CNT_W-1:0]           class_mask;
  logic [CNT_W-1:0]           threshold_d;
  logic [CNT_W-1:0]           threshold_q;
  logic [CNT_W-1:0]           cnt_q;

  // The highest set bit of the setting selects the class
  always_comb begin
    if (dummy_freq[3]) begin
      freq_class = dummy_cfg_pkg::FREQ_64;
    end else if (dummy_freq[2]) begin
      freq_class = dummy_cfg_pkg::FREQ_32;
    end else if (dummy_freq[1]) begin
      freq_class = dummy_cfg_pkg::FREQ_16;
    end else if (dummy_freq[0]) begin
      freq_class = dummy_cfg_pkg::FREQ_8;
    end else begin
      freq_class = dummy_cfg_pkg::FREQ_4;
    end
  end

  always_comb begin
    case (freq_class)
      dummy_cfg_pkg::FREQ_8:  class_mask = CNT_W'(7);
      dummy_cfg_pkg::FREQ_16: class_mask = CNT_W'(15);
      dummy_cfg_pkg::FREQ_32: class_mask = CNT_W'(31);
      dummy_cfg_pkg::FREQ_64: class_mask = CNT_W'(63);
      default:                class_mask = CNT_W'(3);
    endcase
  end

  // Sampled before the LFSRs step, since both change on the same edge
  assign threshold_d = lfsr0[CNT_W-1:0] & class_mask;

  always_ff @(posedge clk_i) begin
    if (!rst_ni || !dummy_en || dummy_accept) begin
      cnt_q       <= '0;
      threshold_q <= threshold_d;
    end else if (normal_accept && !dummy_due) begin
      // Saturates at the threshold, so a word taken on the enable edge cannot skip it
      cnt_q <= cnt_q + CNT_W'(1);
    end
  end

  assign dummy_due = (cnt_q == threshold_q);

endmodule

/* source/dummy_lfsr_bank.sv */
`timescale 1ns/10ps

`include "dummy_settings.svh"

module dummy_lfsr_bank (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          step,
  input  logic                          seed_we,
  input  dummy_cfg_pkg::lfsr_sel_e      seed_sel,
  input  logic [`DUMMY_LFSR_W-1:0]      seed_wdata,
  output logic [`DUMMY_LFSR_W-1:0]      lfsr0,
  output logic [`DUMMY_LFSR_W-1:0]      lfsr1,
  output logic [`DUMMY_LFSR_W-1:0]      lfsr2
);

  localparam int W = `DUMMY_LFSR_W;
  localparam logic [W-1:0] TAPS = `DUMMY_LFSR_TAPS;

  localparam logic [W-1:0] DEFAULT_SEED [3] = '{
    `DUMMY_SEED0,
    `DUMMY_SEED1,
    `DUMMY_SEED2
  };

  logic [W-1:0] lfsr_q    [3];
  logic [W-1:0] lfsr_step [3];
  logic         sel_hit   [3];

  for (genvar i = 0; i < 3; i++) begin : g_lfsr

    // Right-shifting Galois form: the bit shifted out folds the taps back in
    assign lfsr_step[i] = {1'b0, lfsr_q[i][W-1:1]} ^ (lfsr_q[i][0] ? TAPS : '0);

    assign sel_hit[i] = seed_we && (seed_sel == dummy_cfg_pkg::lfsr_sel_e'(i));

    always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
        lfsr_q[i] <= DEFAULT_SEED[i];
      end else if (sel_hit[i]) begin
        // A zero seed would lock the register, so the default goes in instead
        if (seed_wdata == '0) begin
          lfsr_q[i] <= DEFAULT_SEED[i];
        end else begin
          lfsr_q[i] <= seed_wdata;
        end
      end else if (step) begin
        if (lfsr_step[i] == '0) begin
          lfsr_q[i] <= DEFAULT_SEED[i];
        end else begin
          lfsr_q[i] <= lfsr_step[i];
        end
      end
    end

  end

  // LFSR0 picks the opcode and the spacing, LFSR1 and LFSR2 feed the operands
  assign lfsr0 = lfsr_q[0];
  assign lfsr1 = lfsr_q[1];
  assign lfsr2 = lfsr_q[2];

endmodule

/* source/dummy_cfg_pkg.sv */
package dummy_cfg_pkg;

  // Size class picked by the four-bit frequency setting
  // A class of N allows at most N-1 normal words between two dummies
  typedef enum logic [2:0] {
    FREQ_4  = 3'd0,
    FREQ_8  = 3'd1,
    FREQ_16 = 3'd2,
    FREQ_32 = 3'd3,
    FREQ_64 = 3'd4
  } freq_class_e;

  // Issue port controller states
  // ST_OFF and ST_RUN pass fetched words, ST_DUMMY owns the issue port
  typedef enum logic [1:0] {
    ST_OFF   = 2'd0,
    ST_RUN   = 2'd1,
    ST_DUMMY = 2'd2
  } ctrl_state_e;

  // Target of a seed write
  typedef enum logic [1:0] {
    LFSR0 = 2'd0,
    LFSR1 = 2'd1,
    LFSR2 = 2'd2
  } lfsr_sel_e;

endpackage

/* source/rv_instr_pkg.sv */
package rv_instr_pkg;

  // Major opcodes used by the dummy instructions
  localparam logic [6:0] OPCODE_OP     = 7'b0110011;
  localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;

  // MUL shares its funct3 with ADD and is told apart by funct7
  localparam logic [2:0] FUNCT3_ADD  = 3'b000;
  localparam logic [2:0] FUNCT3_AND  = 3'b111;
  localparam logic [2:0] FUNCT3_BLTU = 3'b110;

  // AND uses the same funct7 as ADD
  localparam logic [6:0] FUNCT7_ADD = 7'b0000000;
  localparam logic [6:0] FUNCT7_MUL = 7'b0000001;

  localparam logic [4:0] REG_X0 = 5'd0;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_type_t;

  // Branch immediate is split across the word as in the ISA manual
  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_type_t;

  // One instruction word, read as R-type for ALU dummies and as B-type for BLTU
  typedef union packed {
    r_type_t r;
    b_type_t b;
  } instr_u;

endpackage

/* source/dummy_settings.svh */
`ifndef DUMMY_SETTINGS_SVH
`define DUMMY_SETTINGS_SVH

// Width of each of the three LFSRs and of the operands they feed
`define DUMMY_LFSR_W 32

// Galois feedback mask for x^32 + x^22 + x^2 + x + 1
// The polynomial is maximal length, so a nonzero state never reaches zero
`define DUMMY_LFSR_TAPS 32'h8020_0003

// Default seeds, loaded at reset and on lockup recovery
// All of them must be nonzero
`define DUMMY_SEED0 32'h3a5c_e1d7
`define DUMMY_SEED1 32'h91b4_0f6e
`define DUMMY_SEED2 32'h5d27_c8a3

// Width of the interval counter and its threshold
// Six bits cover the largest class, where up to 63 normal words pass
`define DUMMY_CNT_W 6

`endif
